// ==== bench/clockGen.sv ====
// testbench clock and reset source
// free-running clock, reset held low for a fixed number of cycles
`timescale 1ns/1ps

module clockGen #(
	parameter int halfPeriod  = 20,
	parameter int resetCycles = 16
) (
	output logic Clk,
	output logic rstN
);

	initial begin
		Clk = 1'b0;
		forever #halfPeriod Clk = ~Clk;
	end

	// release just after an edge, like the other inputs
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge Clk);
		#2;
		rstN = 1'b1;
	end

endmodule

// ==== bench/huntGameTb.sv ====
// testbench for the shooting gallery core
// reference model of counters, syncs, cursor, fire history and target
// per-cycle compare of pixel, syncs and score digits
// scripted frames for clamping, the walk/fly/hidden path, hits and misses
`timescale 1ns/1ps

module huntGameTb import huntPkg::*; ();

	// small screen so a frame is 80 x 52 cycles
	localparam int hActive = 64;
	localparam int hFront = 4;
	localparam int hSync = 8;
	localparam int hBack = 4;
	localparam int vActive = 48;
	localparam int vFront = 1;
	localparam int vSync = 2;
	localparam int vBack = 1;
	localparam int hTotal = hActive + hFront + hSync + hBack;
	localparam int vTotal = vActive + vFront + vSync + vBack;
	localparam int walkLine = vActive - 16;
	localparam int cycleLimit = 40 * hTotal * vTotal + 64;

	logic Clk;
	logic rstN;
	mouseT mouse;
	logic hs;
	logic vs;
	rgbT pixel;
	logic [6:0] hexTens;
	logic [6:0] hexOnes;

	// ========================================================================
	// model state mirroring the DUT registers after the last edge
	// ========================================================================

	int hCnt;
	int vCnt;
	int pixX;
	int pixY;
	rgbT pixelExp;
	logic hsExp;
	logic vsExp;
	int curX;
	int curY;
	logic fireHeld;
	int dogX;
	int dogY;
	dogStateT dogState;
	int hideCount;
	int anim;
	int score;
	bit visited [4];
	int frameCount = 0;
	bit modelValid = 1'b0;
	// compare bookkeeping
	int samples = 0;
	int lastVsFall = -1;
	logic vsPrev = 1'b1;
	int errPixel = 0;
	int errSync = 0;
	int errScore = 0;
	int errOther = 0;

	clockGen #(.halfPeriod(20), .resetCycles(16)) clockInst (.Clk, .rstN);

	huntGame #(
		.hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
		.vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
	) huntGame_inst (
		.Clk, .rstN, .mouse, .hs, .vs, .pixel, .hexTens, .hexOnes
	);

	// seven segments g..a inverted for active low
	function automatic logic [6:0] segmentsFor(input int digit);
		logic [6:0] lit;
		case (digit)
			0: lit = 7'h3F;
			1: lit = 7'h06;
			2: lit = 7'h5B;
			3: lit = 7'h4F;
			4: lit = 7'h66;
			5: lit = 7'h6D;
			6: lit = 7'h7D;
			7: lit = 7'h07;
			8: lit = 7'h7F;
			default: lit = 7'h6F;
		endcase
		return ~lit;
	endfunction

	function automatic bit inBox(input int px, input int py, input int bx, input int by,
		input int w, input int h);
		return (px >= bx) && (px < bx + w) && (py >= by) && (py < by + h);
	endfunction

	function automatic int clampTo(input int value, input int hi);
		if (value < 0) begin
			return 0;
		end else if (value > hi) begin
			return hi;
		end else begin
			return value;
		end
	endfunction

	// colour expected at one draw position in screen priority order
	function automatic rgbT expectedColour(input int x, input int y);
		if ((x >= hActive) || (y >= vActive)) begin
			return '0;
		end else if (inBox(x, y, curX, curY, cursorSize, cursorSize)) begin
			return cursorColor;
		end else if ((dogState != dogHidden) && inBox(x, y, dogX, dogY, dogSizeX, dogSizeY)) begin
			return dogColors[anim];
		end else if (y >= vActive - 8) begin
			return grassColor;
		end else begin
			return skyColor;
		end
	endfunction

	// one frame tick with the dog first since it sees the old cursor
	task automatic frameUpdate();
		bit shotNow;
		bit alive;
		shotNow = mouse.fire && !fireHeld;
		alive = (dogState == dogWalk) || (dogState == dogFly);
		if (alive) begin
			anim = (anim + 1) % 4;
		end
		if (shotNow && alive && inBox(curX, curY, dogX, dogY, dogSizeX, dogSizeY)) begin
			// dog frozen for this tick and score saturating at 99
			dogState = dogFall;
			score = (score < 99) ? score + 1 : 99;
		end else begin
			case (dogState)
				dogWalk: begin
					dogX += dogStep;
					if (dogX >= hActive / 2) begin
						dogState = dogFly;
					end
				end
				dogFly: begin
					dogX += dogStep;
					dogY = (dogY > dogStep) ? dogY - dogStep : 0;
					if ((dogY == 0) || (dogX >= hActive - dogSizeX)) begin
						dogState = dogHidden;
					end
				end
				dogFall: begin
					dogY = clampTo(dogY + 2 * dogStep, walkLine);
					if (dogY == walkLine) begin
						dogState = dogHidden;
					end
				end
				default: begin
					hideCount++;
					if (hideCount == hiddenFrames) begin
						// respawn at the left edge
						hideCount = 0;
						dogState = dogWalk;
						dogX = 0;
						dogY = walkLine;
					end
				end
			endcase
		end
		visited[dogState] = 1'b1;
		curX = clampTo(curX + int'(mouse.dx), hActive - cursorSize);
		curY = clampTo(curY + int'(mouse.dy), vActive - cursorSize);
		fireHeld = mouse.fire;
		frameCount++;
	endtask

	// state after the coming rising edge with inputs already stable
	task automatic advanceModel();
		if (!rstN) begin
			// counters park in the blanked tail of the last line
			hCnt = hActive;
			vCnt = vTotal - 1;
			pixX = -1;
			pixY = -1;
			pixelExp = '0;
			hsExp = 1'b1;
			vsExp = 1'b1;
			curX = hActive / 2;
			curY = vActive / 2;
			fireHeld = 1'b0;
			dogX = 0;
			dogY = walkLine;
			dogState = dogWalk;
			hideCount = 0;
			anim = 0;
			score = 0;
			modelValid = 1'b1;
		end else begin
			pixX = hCnt;
			pixY = vCnt;
			pixelExp = expectedColour(hCnt, vCnt);
			hsExp = !((hCnt >= hActive + hFront) && (hCnt < hActive + hFront + hSync));
			vsExp = !((vCnt >= vActive + vFront) && (vCnt < vActive + vFront + vSync));
			if ((vCnt == vActive) && (hCnt == 0)) begin
				frameUpdate();
			end
			if (hCnt == hTotal - 1) begin
				hCnt = 0;
				vCnt = (vCnt + 1) % vTotal;
			end else begin
				hCnt++;
			end
		end
	endtask

	// ========================================================================
	// compare on the falling edge where outputs have settled
	// ========================================================================

	always @(negedge Clk) begin
		if (modelValid) begin
			samples++;
			assert (pixel === pixelExp) else begin
				errPixel++;
				$display("Mismatch at %0d ns: pixel at (%0d,%0d) expected %h, got %h",
					$time, pixX, pixY, pixelExp, pixel);
			end
			assert ((hs === hsExp) && (vs === vsExp)) else begin
				errSync++;
				$display("Mismatch at %0d ns: syncs at (%0d,%0d) expected hs %b vs %b, got %b %b",
					$time, pixX, pixY, hsExp, vsExp, hs, vs);
			end
			assert ((hexTens === segmentsFor(score / 10)) &&
				(hexOnes === segmentsFor(score % 10))) else begin
				errScore++;
				$display("Mismatch at %0d ns: score %0d expected digits %b %b, got %b %b",
					$time, score, segmentsFor(score / 10), segmentsFor(score % 10),
					hexTens, hexOnes);
			end
			// frame period from one vsync start to the next
			if (vsPrev && !vs) begin
				if (lastVsFall >= 0) begin
					assert (samples - lastVsFall == hTotal * vTotal) else begin
						errOther++;
						$display("Mismatch at %0d ns: frame period %0d cycles, expected %0d",
							$time, samples - lastVsFall, hTotal * vTotal);
					end
				end
				lastVsFall = samples;
			end
			vsPrev = vs;
		end
		advanceModel();
	end

	task automatic reportAndStop();
		$display("errors: pixel %0d, sync %0d, score %0d, other %0d",
			errPixel, errSync, errScore, errOther);
		if (errPixel + errSync + errScore + errOther == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	// ========================================================================
	// stimulus
	// ========================================================================

	// hold one mouse sample until the next frame tick has used it
	task automatic playFrame(input int dx, input int dy, input logic fire);
		int seen;
		seen = frameCount;
		mouse.dx = 8'(dx);
		mouse.dy = 8'(dy);
		mouse.fire = fire;
		wait (frameCount != seen);
		@(posedge Clk);
		#2;
	endtask

	task automatic moveCursorTo(input int tx, input int ty, input logic fire);
		playFrame(tx - curX, ty - curY, fire);
	endtask

	// lead the target by one step so the cursor lands inside its box
	task automatic aimAtDog(input logic fire);
		int ny;
		ny = (dogState == dogFly) ? dogY - dogStep : dogY;
		moveCursorTo(dogX + dogStep + 2, ny + 2, fire);
	endtask

	initial begin
		logic [31:0] rnd;
		void'($urandom(50));
		mouse = '0;
		wait (rstN === 1'b1);
		@(posedge Clk);
		#2;
		// clamp top-left then bottom-right
		playFrame(-128, -128, 1'b0);
		playFrame(127, 127, 1'b0);
		for (int i = 0; i < 6; i++) begin
			rnd = $urandom;
			playFrame(int'($signed(rnd[7:0])), int'($signed(rnd[15:8])), 1'b0);
		end
		// press far from the dog and slide onto it with fire still held
		moveCursorTo(0, 0, 1'b0);
		playFrame(0, 0, 1'b1);
		aimAtDog(1'b1);
		playFrame(0, 0, 1'b1);
		playFrame(0, 0, 1'b0);
		// untouched walk and flight until it hides
		while (dogState != dogHidden) begin
			playFrame(0, 0, 1'b0);
		end
		// press on the hidden box
		moveCursorTo(dogX + 2, dogY + 2, 1'b0);
		playFrame(0, 0, 1'b1);
		while (dogState != dogWalk) begin
			playFrame(0, 0, 1'b0);
		end
		// real hit after respawn with fire kept down afterwards
		aimAtDog(1'b0);
		repeat (3) begin
			playFrame(0, 0, 1'b1);
		end
		playFrame(0, 0, 1'b0);
		// exactly one hit in the whole run shows as 01
		assert ((hexTens === segmentsFor(0)) && (hexOnes === segmentsFor(1))) else begin
			errScore++;
			$display("Mismatch at %0d ns: final digits expected a score of one, got %b %b",
				$time, hexTens, hexOnes);
		end
		assert (visited[dogWalk] && visited[dogFly] && visited[dogFall] &&
			visited[dogHidden]) else begin
			errOther++;
			$display("Scenario error: the target did not pass through every state");
		end
		reportAndStop();
	end

	// run limit counted in clock cycles
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge Clk);
			cycles++;
		end
		errOther++;
		$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
		reportAndStop();
	end

endmodule

// ==== src/cursorTracker.sv ====
// cursor position from signed mouse deltas
// deltas are added once per frame and clamped to the screen
// fire edge detect against the value held from the last tick
`timescale 1ns/1ps

module cursorTracker import huntPkg::*; #(
	parameter int hActive = 640,
	parameter int vActive = 480
) (
	input  logic  Clk,
	input  logic  rstN,
	input  logic  frameTick,
	input  mouseT mouse,
	output posT   cursor,
	output logic  shot
);

	// cursor square must stay fully on screen
	localparam int maxX = hActive - cursorSize;
	localparam int maxY = vActive - cursorSize;

	// two guard bits catch both under and overflow
	logic signed [11:0] sumX;
	logic signed [11:0] sumY;
	// fire level seen on the previous tick
	logic fireHeld;

	function automatic coordT clampCoord(input logic signed [11:0] value, input int limit);
		if (value < 0) begin
			return '0;
		end else if (value > limit) begin
			return coordT'(limit);
		end else begin
			return value[9:0];
		end
	endfunction

	// zero-extend the position, sign-extend the delta
	assign sumX = $signed({2'b00, cursor.x}) + mouse.dx;
	assign sumY = $signed({2'b00, cursor.y}) + mouse.dy;

	// rising edge of fire, only on the sampling cycle
	assign shot = frameTick && mouse.fire && !fireHeld;

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			// screen centre
			cursor.x <= coordT'(hActive / 2);
			cursor.y <= coordT'(vActive / 2);
			fireHeld <= 1'b0;
		end else if (frameTick) begin
			cursor.x <= clampCoord(sumX, maxX);
			cursor.y <= clampCoord(sumY, maxY);
			fireHeld <= mouse.fire;
		end
	end

endmodule

// ==== src/dogControl.sv ====
// target state machine
// walk along the grass line, fly up and away, fall when shot
// hidden for a few frames, then respawn at the left edge
// animation frame counter and saturating score
`timescale 1ns/1ps

module dogControl import huntPkg::*; #(
	parameter int hActive = 640,
	parameter int vActive = 480
) (
	input  logic       Clk,
	input  logic       rstN,
	input  logic       frameTick,
	input  logic       shot,
	input  posT        cursor,
	output posT        dog,
	output logic       dogVisible,
	output logic [1:0] animFrame,
	output scoreT      score
);

	// ground level for walking and for landing after a fall
	localparam coordT walkLine = coordT'(vActive - 16);
	// walk turns into flight here
	localparam coordT halfX    = coordT'(hActive / 2);
	// flight ends at the right edge
	localparam coordT flyEdgeX = coordT'(hActive - dogSizeX);
	localparam coordT stepC    = coordT'(dogStep);
	localparam coordT fallStep = coordT'(2 * dogStep);

	dogStateT state;
	// ticks spent hidden so far
	logic [2:0] hideCnt;
	// x after one step to the right
	coordT stepX;
	coordT fallY;
	logic inBox;
	logic hit;

	assign stepX = dog.x + stepC;
	assign fallY = dog.y + fallStep;

	// cursor top-left corner over the dog box
	assign inBox = (cursor.x >= dog.x) && (cursor.x < dog.x + coordT'(dogSizeX)) &&
		(cursor.y >= dog.y) && (cursor.y < dog.y + coordT'(dogSizeY));

	// only a moving dog can be hit
	assign hit = shot && inBox && ((state == dogWalk) || (state == dogFly));

	assign dogVisible = (state != dogHidden);

	// ========================================================================
	// per-frame update
	// ========================================================================

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			state     <= dogWalk;
			dog.x     <= '0;
			dog.y     <= walkLine;
			animFrame <= '0;
			score     <= '0;
			hideCnt   <= '0;
		end else if (frameTick) begin
			// legs and wings move only while alive
			if ((state == dogWalk) || (state == dogFly)) begin
				animFrame <= animFrame + 2'd1;
			end

			if (hit) begin
				// dog freezes in place for this tick, then drops
				state <= dogFall;
				if (score != scoreT'(99)) begin
					score <= score + scoreT'(1);
				end
			end else begin
				case (state)
					dogWalk: begin
						dog.x <= stepX;
						if (stepX >= halfX) begin
							state <= dogFly;
						end
					end
					dogFly: begin
						// up and to the right
						dog.x <= stepX;
						if (dog.y <= stepC) begin
							dog.y <= '0;
							state <= dogHidden;
						end else begin
							dog.y <= dog.y - stepC;
							if (stepX >= flyEdgeX) begin
								state <= dogHidden;
							end
						end
					end
					dogFall: begin
						// double speed, stop on the walk line
						if (fallY >= walkLine) begin
							dog.y <= walkLine;
							state <= dogHidden;
						end else begin
							dog.y <= fallY;
						end
					end
					dogHidden: begin
						if (hideCnt == 3'(hiddenFrames - 1)) begin
							// respawn
							hideCnt <= '0;
							state   <= dogWalk;
							dog.x   <= '0;
							dog.y   <= walkLine;
						end else begin
							hideCnt <= hideCnt + 3'd1;
						end
					end
				endcase
			end
		end
	end

endmodule

// ==== src/huntGame.sv ====
// shooting gallery core top level
// timing, cursor, target control, colour mapper and score digits
// syncs delayed one clock to line up with the registered pixel
`timescale 1ns/1ps

module huntGame import huntPkg::*; #(
	parameter int hActive = 640,
	parameter int hFront  = 16,
	parameter int hSync   = 96,
	parameter int hBack   = 48,
	parameter int vActive = 480,
	parameter int vFront  = 10,
	parameter int vSync   = 2,
	parameter int vBack   = 33
) (
	input  logic       Clk,
	input  logic       rstN,
	input  mouseT      mouse,
	output logic       hs,
	output logic       vs,
	output rgbT        pixel,
	output logic [6:0] hexTens,
	output logic [6:0] hexOnes
);

	// ========================================================================
	// internal nets
	// ========================================================================

	posT        drawPos;
	logic       blank;
	// syncs straight from the counters
	logic       hsRaw;
	logic       vsRaw;
	logic       frameTick;
	posT        cursor;
	logic       shot;
	posT        dog;
	logic       dogVisible;
	logic [1:0] animFrame;
	scoreT      score;

	videoTiming #(
		.hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
		.vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
	) timingInst (
		.Clk, .rstN, .drawPos, .blank, .hs(hsRaw), .vs(vsRaw), .frameTick
	);

	cursorTracker #(.hActive(hActive), .vActive(vActive)) cursorInst (
		.Clk, .rstN, .frameTick, .mouse, .cursor, .shot
	);

	dogControl #(.hActive(hActive), .vActive(vActive)) dogInst (
		.Clk, .rstN, .frameTick, .shot, .cursor, .dog, .dogVisible, .animFrame, .score
	);

	pixelMapper #(.vActive(vActive)) mapperInst (
		.Clk, .rstN, .drawPos, .blank, .cursor, .dog, .dogVisible, .animFrame, .pixel
	);

	scoreDisplay scoreInst (.score, .hexTens, .hexOnes);

	// one stage to match the pixel register, idle high
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			hs <= 1'b1;
			vs <= 1'b1;
		end else begin
			hs <= hsRaw;
			vs <= vsRaw;
		end
	end

endmodule

// ==== src/huntPkg.sv ====
// types and constants shared by the shooting gallery core
// screen coordinates, colour channels and packed pixel colour
// draw position and mouse sample structs
// target state encoding and score width
// sprite sizes, motion step, hidden time and palette
package huntPkg;

	// ========================================================================
	// plain widths
	// ========================================================================

	// one screen axis
	typedef logic [9:0] coordT;
	// one colour channel of the dac
	typedef logic [3:0] channelT;
	// score, saturates at 99
	typedef logic [6:0] scoreT;

	// ========================================================================
	// grouped signals
	// ========================================================================

	typedef struct packed {
		channelT red;
		channelT green;
		channelT blue;
	} rgbT;

	// draw position, cursor and dog all use this
	typedef struct packed {
		coordT x;
		coordT y;
	} posT;

	// one mouse sample, deltas are two's complement
	typedef struct packed {
		logic signed [7:0] dx;
		logic signed [7:0] dy;
		logic              fire;
	} mouseT;

	typedef enum logic [1:0] {
		dogWalk,
		dogFly,
		dogFall,
		dogHidden
	} dogStateT;

	// sprite geometry and motion
	localparam int cursorSize   = 4;
	localparam int dogSizeX     = 8;
	localparam int dogSizeY     = 8;
	localparam int dogStep      = 2;
	localparam int hiddenFrames = 4;

	// palette
	localparam rgbT skyColor    = rgbT'(12'h6AF);
	localparam rgbT grassColor  = rgbT'(12'h2A2);
	localparam rgbT cursorColor = rgbT'(12'hF00);
	// one colour per animation frame
	localparam rgbT dogColors [4] = '{rgbT'(12'h963), rgbT'(12'hA74),
		rgbT'(12'hB85), rgbT'(12'h852)};

endpackage

// ==== src/pixelMapper.sv ====
// pixel colour selection
// priority: blank, cursor, visible dog, grass strip, sky
// output registered, one cycle behind the draw position
`timescale 1ns/1ps

module pixelMapper import huntPkg::*; #(
	parameter int vActive = 480
) (
	input  logic       Clk,
	input  logic       rstN,
	input  posT        drawPos,
	input  logic       blank,
	input  posT        cursor,
	input  posT        dog,
	input  logic       dogVisible,
	input  logic [1:0] animFrame,
	output rgbT        pixel
);

	// grass covers the bottom rows
	localparam coordT grassTop = coordT'(vActive - 8);

	logic inCursor;
	logic inDog;
	rgbT  colour;

	// cursor square hit test
	assign inCursor = (drawPos.x >= cursor.x) && (drawPos.x < cursor.x + coordT'(cursorSize)) &&
		(drawPos.y >= cursor.y) && (drawPos.y < cursor.y + coordT'(cursorSize));

	// dog box hit test
	assign inDog = (drawPos.x >= dog.x) && (drawPos.x < dog.x + coordT'(dogSizeX)) &&
		(drawPos.y >= dog.y) && (drawPos.y < dog.y + coordT'(dogSizeY));

	always_comb begin
		if (blank) begin
			colour = '0;
		end else if (inCursor) begin
			colour = cursorColor;
		end else if (inDog && dogVisible) begin
			// colour follows the animation frame
			colour = dogColors[animFrame];
		end else if (drawPos.y >= grassTop) begin
			colour = grassColor;
		end else begin
			colour = skyColor;
		end
	end

	// output register, black out of reset
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			pixel <= '0;
		end else begin
			pixel <= colour;
		end
	end

endmodule

// ==== src/scoreDisplay.sv ====
// score to two seven-segment digits
// binary split into tens and ones, active low segments
`timescale 1ns/1ps

module scoreDisplay import huntPkg::*; (
	input  scoreT      score,
	output logic [6:0] hexTens,
	output logic [6:0] hexOnes
);

	logic [3:0] tens;
	logic [3:0] ones;

	// segment order g..a, low lights the segment
	function automatic logic [6:0] segDecode(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			// never reached, score stays below 100
			default: return 7'b1111111;
		endcase
	endfunction

	// constant divide, small enough for plain logic
	assign tens = 4'(score / scoreT'(10));
	assign ones = 4'(score % scoreT'(10));

	assign hexTens = segDecode(tens);
	assign hexOnes = segDecode(ones);

endmodule

// ==== src/videoTiming.sv ====
// video timing generator
// horizontal and vertical wrap-around counters
// active low syncs, blank and draw position
// one-cycle frame tick at the start of vertical blanking
`timescale 1ns/1ps

module videoTiming import huntPkg::*; #(
	parameter int hActive = 640,
	parameter int hFront  = 16,
	parameter int hSync   = 96,
	parameter int hBack   = 48,
	parameter int vActive = 480,
	parameter int vFront  = 10,
	parameter int vSync   = 2,
	parameter int vBack   = 33
) (
	input  logic Clk,
	input  logic rstN,
	output posT  drawPos,
	output logic blank,
	output logic hs,
	output logic vs,
	output logic frameTick
);

	localparam int hTotal = hActive + hFront + hSync + hBack;
	localparam int vTotal = vActive + vFront + vSync + vBack;

	// sync windows, start inclusive and end exclusive
	localparam coordT hSyncStart = coordT'(hActive + hFront);
	localparam coordT hSyncEnd   = coordT'(hActive + hFront + hSync);
	localparam coordT vSyncStart = coordT'(vActive + vFront);
	localparam coordT vSyncEnd   = coordT'(vActive + vFront + vSync);

	coordT hCount;
	coordT vCount;

	// ========================================================================
	// counters
	// ========================================================================

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			// park in the blanked tail of the last line
			// so syncs idle high and the next line opens frame 0
			hCount <= coordT'(hActive);
			vCount <= coordT'(vTotal - 1);
		end else begin
			if (hCount == coordT'(hTotal - 1)) begin
				hCount <= '0;
				// end of line
				if (vCount == coordT'(vTotal - 1)) begin
					vCount <= '0;
				end else begin
					vCount <= vCount + 10'd1;
				end
			end else begin
				hCount <= hCount + 10'd1;
			end
		end
	end

	// ========================================================================
	// decoded outputs
	// ========================================================================

	assign drawPos.x = hCount;
	assign drawPos.y = vCount;

	// outside the visible area on either axis
	assign blank = (hCount >= coordT'(hActive)) || (vCount >= coordT'(vActive));

	// low only inside the sync pulse
	assign hs = !((hCount >= hSyncStart) && (hCount < hSyncEnd));
	assign vs = !((vCount >= vSyncStart) && (vCount < vSyncEnd));

	// first cycle of the first blanked line
	assign frameTick = (vCount == coordT'(vActive)) && (hCount == '0);

endmodule

// ==== verilog.f ====
src/huntPkg.sv
src/videoTiming.sv
src/cursorTracker.sv
src/dogControl.sv
src/pixelMapper.sv
src/scoreDisplay.sv
src/huntGame.sv
bench/clockGen.sv
bench/huntGameTb.sv
